// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_decode
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/decode_assert.sv
`timescale 1ns/1ns

// Output checks on execute_unit, attached by bind from the testbench
module decode_assert (
  input logic                 CLK,
  input logic                 nRST,
  input logic                 wb_valid,
  input decode_pkg::reg_idx_t wb_rd,
  input decode_pkg::word_t    wb_data,
  input logic                 jump_valid,
  input decode_pkg::word_t    jump_target,
  input logic                 illegal,
  input logic                 fence_pulse
);

  no_wb_on_illegal: assert property (@(posedge CLK) disable iff (!nRST)
    !(illegal && wb_valid))
    else $error("illegal and wb_valid are high in the same cycle");

  single_fence_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    fence_pulse |=> !fence_pulse)
    else $error("fence_pulse is high two cycles in a row");

  // Targets are at least halfword aligned
  target_bit0_clear: assert property (@(posedge CLK) disable iff (!nRST)
    jump_valid |-> !jump_target[0])
    else $error("jump_target bit 0 set while jump_valid is high");

  quiet_in_reset: assert property (@(posedge CLK)
    !nRST |-> (!wb_valid && wb_rd == '0 && wb_data == '0 && !jump_valid &&
               jump_target == '0 && !illegal && !fence_pulse))
    else $error("an output is not low during reset");

endmodule

// File: bench/tb_decode.sv
`timescale 1ns/1ns

module tb_decode;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int N_IDLE  = 20;
  localparam int N_ALU   = 300;
  localparam int N_STALL = 300;
  localparam int N_FENCE = 200;
  localparam int N_ILL   = 200;
  localparam int N_MIX   = 400;
  // Each test ends with two idle slots, the run with a final drain of two
  localparam int TOTAL_CYCLES = RESET_CYCLES + N_IDLE + N_ALU + N_STALL + N_FENCE +
                                N_ILL + N_MIX + 6 * 2 + 2;
  localparam int MARGIN = 100;

  // Generator instruction kinds
  localparam int K_OPIMM   = 0;
  localparam int K_OP      = 1;
  localparam int K_LUI     = 2;
  localparam int K_AUIPC   = 3;
  localparam int K_JAL     = 4;
  localparam int K_JALR    = 5;
  localparam int K_FENCE   = 6;
  localparam int K_ILLEGAL = 7;

  typedef struct packed {
    logic                 wb_valid;
    decode_pkg::reg_idx_t wb_rd;
    decode_pkg::word_t    wb_data;
    logic                 jump_valid;
    decode_pkg::word_t    jump_target;
    logic                 illegal;
    logic                 fence_pulse;
  } out_t;

  logic                 CLK;
  logic                 nRST;
  logic                 instr_valid;
  decode_pkg::word_t    instr;
  decode_pkg::word_t    pc;
  logic                 stall;
  logic                 flush;
  logic                 wb_valid;
  decode_pkg::reg_idx_t wb_rd;
  decode_pkg::word_t    wb_data;
  logic                 jump_valid;
  decode_pkg::word_t    jump_target;
  logic                 illegal;
  logic                 fence_pulse;

  // Architectural model
  decode_pkg::word_t regs [0:31];
  logic              fence_prev;
  decode_pkg::word_t pc_next;
  out_t              exp_q [$];

  // Instruction held by the source until it is taken or flushed
  logic                 pending;
  int                   p_kind;
  logic [2:0]           p_f3;
  logic                 p_alt;
  decode_pkg::reg_idx_t p_rd;
  decode_pkg::reg_idx_t p_rs1;
  decode_pkg::reg_idx_t p_rs2;
  decode_pkg::word_t    p_imm;
  decode_pkg::word_t    p_pc;
  decode_pkg::word_t    p_word;

  string cur_test;
  int    checks;
  int    errors;
  int    tests_passed;
  int    tests_failed;

  decode_top UUT (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .stall       (stall),
    .flush       (flush),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .jump_valid  (jump_valid),
    .jump_target (jump_target),
    .illegal     (illegal),
    .fence_pulse (fence_pulse)
  );

  bind execute_unit decode_assert u_assert (
    .CLK         (CLK),
    .nRST        (nRST),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .jump_valid  (jump_valid),
    .jump_target (jump_target),
    .illegal     (illegal),
    .fence_pulse (fence_pulse)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #((TOTAL_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", TOTAL_CYCLES + MARGIN);
    $display("Something failed");
    $finish;
  end

  function automatic decode_pkg::word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic decode_pkg::word_t sext21(input logic [20:0] v);
    return {{11{v[20]}}, v};
  endfunction

  // RV32I integer result by funct3, alt picks SUB and SRA
  function automatic decode_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                input decode_pkg::word_t a,
                                                input decode_pkg::word_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_word(input string what, input decode_pkg::word_t exp,
                            input decode_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h at %0t", cur_test, what, exp, act, $time);
    end
  endtask

  task automatic check_idx(input string what, input decode_pkg::reg_idx_t exp,
                           input decode_pkg::reg_idx_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %0d, actual %0d at %0t", cur_test, what, exp, act, $time);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %b, actual %b at %0t", cur_test, what, exp, act, $time);
    end
  endtask

  task automatic compare_outputs(input out_t e);
    check_bit("wb_valid", e.wb_valid, wb_valid);
    check_idx("wb_rd", e.wb_rd, wb_rd);
    check_word("wb_data", e.wb_data, wb_data);
    check_bit("jump_valid", e.jump_valid, jump_valid);
    check_word("jump_target", e.jump_target, jump_target);
    check_bit("illegal", e.illegal, illegal);
    check_bit("fence_pulse", e.fence_pulse, fence_pulse);
  endtask

  task automatic gen_instr(input int kind);
    p_kind = kind;
    p_rd   = 5'($urandom_range(0, 7));
    p_rs1  = 5'($urandom_range(0, 7));
    p_rs2  = 5'($urandom_range(0, 7));
    p_f3   = 3'($urandom_range(0, 7));
    p_alt  = 1'b0;
    p_imm  = $urandom;
    p_pc   = pc_next;
    pc_next = pc_next + 32'd4;
    case (kind)
      K_OPIMM: begin
        if (p_f3 == 3'b001 || p_f3 == 3'b101) begin
          p_alt  = (p_f3 == 3'b101) ? 1'($urandom_range(0, 1)) : 1'b0;
          p_imm  = {27'b0, p_imm[4:0]};
          p_word = {1'b0, p_alt, 5'b0, p_imm[4:0], p_rs1, p_f3, p_rd, decode_pkg::OPC_OP_IMM};
        end else begin
          p_imm  = sext12(p_imm[11:0]);
          p_word = {p_imm[11:0], p_rs1, p_f3, p_rd, decode_pkg::OPC_OP_IMM};
        end
      end
      K_OP: begin
        if (p_f3 == 3'b000 || p_f3 == 3'b101) p_alt = 1'($urandom_range(0, 1));
        p_word = {1'b0, p_alt, 5'b0, p_rs2, p_rs1, p_f3, p_rd, decode_pkg::OPC_OP};
      end
      K_LUI, K_AUIPC: begin
        p_imm  = {p_imm[31:12], 12'b0};
        p_word = {p_imm[31:12], p_rd,
                  (kind == K_LUI) ? decode_pkg::OPC_LUI : decode_pkg::OPC_AUIPC};
      end
      K_JAL: begin
        p_imm  = sext21({p_imm[20:1], 1'b0});
        p_word = {p_imm[20], p_imm[10:1], p_imm[11], p_imm[19:12], p_rd, decode_pkg::OPC_JAL};
      end
      K_JALR: begin
        p_imm  = sext12(p_imm[11:0]);
        p_word = {p_imm[11:0], p_rs1, 3'b000, p_rd, decode_pkg::OPC_JALR};
      end
      K_FENCE: p_word = {17'b0, 3'b001, 5'b0, decode_pkg::OPC_MISC_MEM};
      default: begin
        // Load, M extension, SLLI with funct7 set, JALR with funct3 set, plain FENCE
        case ($urandom_range(0, 4))
          0: p_word = {p_imm[24:0], 7'b0000011};
          1: p_word = {7'b0000001, p_rs2, p_rs1, p_f3, p_rd, decode_pkg::OPC_OP};
          2: p_word = {7'b0100000, p_rs2, p_rs1, 3'b001, p_rd, decode_pkg::OPC_OP_IMM};
          3: p_word = {p_imm[11:0], p_rs1, (p_f3 == 3'b000) ? 3'b010 : p_f3, p_rd,
                       decode_pkg::OPC_JALR};
          default: p_word = {p_imm[11:0], 5'b0, 3'b000, 5'b0, decode_pkg::OPC_MISC_MEM};
        endcase
      end
    endcase
  endtask

  // One slot in program order; taken is low for an idle, stalled or flushed slot
  task automatic exec_model(input logic taken);
    out_t              e;
    decode_pkg::word_t res;
    decode_pkg::word_t tgt;
    logic              writes;
    logic              is_fence;
    e        = '0;
    res      = '0;
    tgt      = '0;
    writes   = 1'b0;
    is_fence = 1'b0;
    if (taken) begin
      case (p_kind)
        K_OPIMM: res = alu_ref(p_f3, p_alt, regs[p_rs1], p_imm);
        K_OP:    res = alu_ref(p_f3, p_alt, regs[p_rs1], regs[p_rs2]);
        K_LUI:   res = p_imm;
        K_AUIPC: res = p_pc + p_imm;
        K_JAL: begin
          res = p_pc + 32'd4;
          tgt = p_pc + p_imm;
        end
        K_JALR: begin
          res = p_pc + 32'd4;
          tgt = regs[p_rs1] + p_imm;
          tgt[0] = 1'b0;
        end
        K_FENCE: is_fence = 1'b1;
        default: e.illegal = 1'b1;
      endcase
      writes = (p_kind <= K_JALR);
      if (p_kind == K_JAL || p_kind == K_JALR) begin
        e.jump_valid  = 1'b1;
        e.jump_target = tgt;
      end
      if (writes && p_rd != 5'd0) begin
        e.wb_valid = 1'b1;
        e.wb_rd    = p_rd;
        e.wb_data  = res;
        regs[p_rd] = res;
      end
    end
    e.fence_pulse = is_fence && !fence_prev;
    fence_prev    = is_fence;
    exp_q.push_back(e);
  endtask

  task automatic step(input int p_idle, input int p_stall, input int p_flush,
                      input int p_fence, input int p_illegal);
    logic go;
    logic st;
    logic fl;
    int   r;
    @(posedge CLK);
    #5;
    // Outputs now show the slot driven two steps ago
    if (exp_q.size() == 2) compare_outputs(exp_q.pop_front());
    go = ($urandom_range(0, 99) >= p_idle);
    st = ($urandom_range(0, 99) < p_stall);
    fl = ($urandom_range(0, 99) < p_flush);
    if (go && !pending) begin
      r = int'($urandom_range(0, 99));
      if (r < p_fence) gen_instr(K_FENCE);
      else if (r < p_fence + p_illegal) gen_instr(K_ILLEGAL);
      else gen_instr(int'($urandom_range(0, 5)));
      pending = 1'b1;
    end
    instr_valid = go;
    instr       = go ? p_word : $urandom;
    pc          = go ? p_pc : $urandom;
    stall       = st;
    flush       = fl;
    exec_model(go && !st && !fl);
    if (go && (!st || fl)) pending = 1'b0;
  endtask

  task automatic run_test(input string name, input int cycles, input int p_idle,
                          input int p_stall, input int p_flush, input int p_fence,
                          input int p_illegal);
    int start_errors;
    int start_checks;
    cur_test     = name;
    start_errors = errors;
    start_checks = checks;
    repeat (cycles) step(p_idle, p_stall, p_flush, p_fence, p_illegal);
    // Let the last taken instruction reach the outputs
    repeat (2) step(100, 0, 0, 0, 0);
    if (errors == start_errors) tests_passed++;
    else tests_failed++;
    $display("Test %-12s %6d checks %4d errors  %s", name, checks - start_checks,
             errors - start_errors, (errors == start_errors) ? "passed" : "FAILED");
  endtask

  initial begin
    void'($urandom(46));
    nRST        = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    stall       = 1'b0;
    flush       = 1'b0;
    checks       = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    pending      = 1'b0;
    fence_prev   = 1'b0;
    cur_test     = "reset";
    for (int i = 0; i < 32; i++) regs[i] = '0;
    pc_next = $urandom & 32'hFFFF_FFFC;

    repeat (RESET_CYCLES) @(posedge CLK);
    #5;
    nRST = 1'b1;

    run_test("reset_idle", N_IDLE, 100, 0, 0, 0, 0);
    run_test("alu_ops", N_ALU, 5, 0, 0, 0, 0);
    run_test("stall_flush", N_STALL, 10, 25, 15, 5, 5);
    run_test("fence_runs", N_FENCE, 10, 5, 0, 60, 0);
    run_test("illegal", N_ILL, 10, 0, 0, 5, 40);
    run_test("random_mix", N_MIX, 15, 10, 10, 15, 10);

    cur_test = "drain";
    while (exp_q.size() > 0) begin
      @(posedge CLK);
      #5;
      compare_outputs(exp_q.pop_front());
    end

    $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: design/control_unit.sv
`timescale 1ns/1ns

module control_unit (
  input  decode_pkg::word_t instr,
  output decode_pkg::ctrl_t ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // funct3 to ALU op, alt selects SUB/SRA
  function automatic decode_pkg::alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
    case (f3)
      decode_pkg::F3_ADD:  return alt ? decode_pkg::SUB : decode_pkg::ADD;
      decode_pkg::F3_SLL:  return decode_pkg::SLL;
      decode_pkg::F3_SLT:  return decode_pkg::SLT;
      decode_pkg::F3_SLTU: return decode_pkg::SLTU;
      decode_pkg::F3_XOR:  return decode_pkg::XOR;
      decode_pkg::F3_SR:   return alt ? decode_pkg::SRA : decode_pkg::SRL;
      decode_pkg::F3_OR:   return decode_pkg::OR;
      default:             return decode_pkg::AND;
    endcase
  endfunction

  always_comb begin
    // Raw fields, always sliced the same way
    ctrl.rs1       = instr[19:15];
    ctrl.rs2       = instr[24:20];
    ctrl.rd        = instr[11:7];
    ctrl.imm_I     = instr[31:20];
    ctrl.imm_U     = {instr[31:12], 12'b0};
    ctrl.imm_UJ    = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.shamt     = instr[24:20];
    ctrl.alu_op    = decode_pkg::ADD;
    ctrl.src_a_sel = decode_pkg::RS1;
    ctrl.src_b_sel = decode_pkg::RS2;
    ctrl.w_src     = decode_pkg::NONE;
    ctrl.j_sel     = 1'b0;
    ctrl.jump      = 1'b0;
    ctrl.fence     = 1'b0;
    ctrl.illegal   = 1'b0;

    case (opcode)
      decode_pkg::OPC_OP_IMM: begin
        ctrl.w_src = decode_pkg::ALU;
        if (funct3 == decode_pkg::F3_SLL || funct3 == decode_pkg::F3_SR) begin
          ctrl.src_b_sel = decode_pkg::SHAMT;
          ctrl.alu_op    = f3_to_op(funct3, funct7[5]);
          // Only SRAI may set the alternate funct7
          ctrl.illegal = !(funct7 == decode_pkg::F7_BASE ||
                           (funct7 == decode_pkg::F7_ALT && funct3 == decode_pkg::F3_SR));
        end else begin
          ctrl.src_b_sel = decode_pkg::IMM_I;
          ctrl.alu_op    = f3_to_op(funct3, 1'b0);
        end
      end
      decode_pkg::OPC_OP: begin
        ctrl.w_src  = decode_pkg::ALU;
        ctrl.alu_op = f3_to_op(funct3, funct7[5]);
        ctrl.illegal = !(funct7 == decode_pkg::F7_BASE ||
                         (funct7 == decode_pkg::F7_ALT &&
                          (funct3 == decode_pkg::F3_ADD || funct3 == decode_pkg::F3_SR)));
      end
      decode_pkg::OPC_LUI: begin
        // x0 as operand a gives zero plus the U immediate
        ctrl.rs1       = '0;
        ctrl.src_b_sel = decode_pkg::IMM_U;
        ctrl.w_src     = decode_pkg::ALU;
      end
      decode_pkg::OPC_AUIPC: begin
        ctrl.src_a_sel = decode_pkg::PC;
        ctrl.src_b_sel = decode_pkg::IMM_U;
        ctrl.w_src     = decode_pkg::ALU;
      end
      decode_pkg::OPC_JAL: begin
        ctrl.w_src = decode_pkg::PC4;
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
      end
      decode_pkg::OPC_JALR: begin
        ctrl.w_src   = decode_pkg::PC4;
        ctrl.jump    = 1'b1;
        ctrl.illegal = (funct3 != 3'b000);
      end
      decode_pkg::OPC_MISC_MEM: begin
        // Plain FENCE is not supported
        ctrl.fence   = (funct3 == decode_pkg::F3_FENCE_I);
        ctrl.illegal = (funct3 != decode_pkg::F3_FENCE_I);
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

// File: design/decode_exec_if.sv
`timescale 1ns/1ns

// One decoded instruction on its way from decode to execute
interface decode_exec_if;

  logic               valid;
  decode_pkg::arith_t arith;
  decode_pkg::wb_t    wb;
  decode_pkg::jump_t  jump;
  decode_pkg::exc_t   exc;

  modport decode (
    output valid, arith, wb, jump, exc
  );

  modport buffer_in (
    input valid, arith, wb, jump, exc
  );

  modport execute (
    input valid, arith, wb, jump, exc
  );

endinterface

// File: design/decode_pkg.sv
package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_t;

  typedef enum logic {RS1, PC} src_a_sel_t;
  typedef enum logic [1:0] {RS2, IMM_I, SHAMT, IMM_U} src_b_sel_t;
  typedef enum logic [1:0] {ALU, PC4, NONE} w_src_t;

  // Major opcodes
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_FENCE_I = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef struct packed {
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    alu_op_t    alu_op;
    src_a_sel_t src_a_sel;
    src_b_sel_t src_b_sel;
    w_src_t     w_src;
    logic [11:0] imm_I;
    word_t      imm_U;
    logic [20:0] imm_UJ;
    logic [4:0] shamt;
    logic       j_sel;
    logic       jump;
    logic       fence;
    logic       illegal;
  } ctrl_t;

  typedef struct packed {
    alu_op_t alu_op;
    word_t   port_a;
    word_t   port_b;
  } arith_t;

  typedef struct packed {
    reg_idx_t rd;
    w_src_t   w_src;
    word_t    pc4;
  } wb_t;

  typedef struct packed {
    logic  jump;
    logic  jalr;
    word_t j_base;
    word_t j_offset;
  } jump_t;

  typedef struct packed {
    logic illegal;
    logic fence;
  } exc_t;

endpackage

// File: design/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
  input  logic                 instr_valid,
  input  decode_pkg::word_t    instr,
  input  decode_pkg::word_t    pc,
  output decode_pkg::reg_idx_t rs1_idx,
  output decode_pkg::reg_idx_t rs2_idx,
  input  decode_pkg::word_t    rs1_data,
  input  decode_pkg::word_t    rs2_data,
  decode_exec_if.decode        out
);

  decode_pkg::ctrl_t ctrl;
  decode_pkg::word_t imm_I_ext;
  decode_pkg::word_t imm_UJ_ext;

  control_unit u_cu (
    .instr (instr),
    .ctrl  (ctrl)
  );

  assign rs1_idx = ctrl.rs1;
  assign rs2_idx = ctrl.rs2;

  assign imm_I_ext  = {{20{ctrl.imm_I[11]}}, ctrl.imm_I};
  assign imm_UJ_ext = {{11{ctrl.imm_UJ[20]}}, ctrl.imm_UJ};

  assign out.valid = instr_valid;

  always_comb begin
    out.arith.alu_op = ctrl.alu_op;

    // Operand select
    case (ctrl.src_a_sel)
      decode_pkg::PC: out.arith.port_a = pc;
      default:        out.arith.port_a = rs1_data;
    endcase
    case (ctrl.src_b_sel)
      decode_pkg::IMM_I: out.arith.port_b = imm_I_ext;
      decode_pkg::SHAMT: out.arith.port_b = {27'b0, ctrl.shamt};
      decode_pkg::IMM_U: out.arith.port_b = ctrl.imm_U;
      default:           out.arith.port_b = rs2_data;
    endcase

    out.wb.rd    = ctrl.rd;
    out.wb.w_src = ctrl.w_src;
    out.wb.pc4   = pc + 32'd4;

    // JAL is pc relative, JALR is rs1 relative
    out.jump.jump     = ctrl.jump;
    out.jump.jalr     = ctrl.jump && !ctrl.j_sel;
    out.jump.j_base   = ctrl.j_sel ? pc : rs1_data;
    out.jump.j_offset = ctrl.j_sel ? imm_UJ_ext : imm_I_ext;

    out.exc.illegal = ctrl.illegal;
    out.exc.fence   = ctrl.fence;
  end

endmodule

// File: design/decode_top.sv
`timescale 1ns/1ns

module decode_top (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 instr_valid,
  input  decode_pkg::word_t    instr,
  input  decode_pkg::word_t    pc,
  input  logic                 stall,
  input  logic                 flush,
  output logic                 wb_valid,
  output decode_pkg::reg_idx_t wb_rd,
  output decode_pkg::word_t    wb_data,
  output logic                 jump_valid,
  output decode_pkg::word_t    jump_target,
  output logic                 illegal,
  output logic                 fence_pulse
);

  decode_pkg::reg_idx_t rs1_idx;
  decode_pkg::reg_idx_t rs2_idx;
  decode_pkg::word_t    rs1_data;
  decode_pkg::word_t    rs2_data;
  logic                 we;
  decode_pkg::reg_idx_t waddr;
  decode_pkg::word_t    wdata;

  decode_exec_if d_if ();
  decode_exec_if x_if ();

  decode_stage u_decode (
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .out         (d_if.decode)
  );

  id_ex_reg u_id_ex (
    .CLK   (CLK),
    .nRST  (nRST),
    .stall (stall),
    .flush (flush),
    .in    (d_if.buffer_in),
    .out   (x_if.decode)
  );

  execute_unit u_exec (
    .CLK         (CLK),
    .nRST        (nRST),
    .in          (x_if.execute),
    .we          (we),
    .waddr       (waddr),
    .wdata       (wdata),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .jump_valid  (jump_valid),
    .jump_target (jump_target),
    .illegal     (illegal),
    .fence_pulse (fence_pulse)
  );

  reg_file u_rf (
    .CLK    (CLK),
    .nRST   (nRST),
    .raddr1 (rs1_idx),
    .raddr2 (rs2_idx),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .we     (we),
    .waddr  (waddr),
    .wdata  (wdata)
  );

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  decode_exec_if.execute       in,
  output logic                 we,
  output decode_pkg::reg_idx_t waddr,
  output decode_pkg::word_t    wdata,
  output logic                 wb_valid,
  output decode_pkg::reg_idx_t wb_rd,
  output decode_pkg::word_t    wb_data,
  output logic                 jump_valid,
  output decode_pkg::word_t    jump_target,
  output logic                 illegal,
  output logic                 fence_pulse
);

  decode_pkg::word_t a;
  decode_pkg::word_t b;
  decode_pkg::word_t alu_out;
  decode_pkg::word_t target;
  logic              legal;
  logic              jump_now;
  logic              fence_now;
  logic              fence_prev;

  assign a = in.arith.port_a;
  assign b = in.arith.port_b;

  always_comb begin
    case (in.arith.alu_op)
      decode_pkg::SUB:  alu_out = a - b;
      decode_pkg::SLL:  alu_out = a << b[4:0];
      decode_pkg::SLT:  alu_out = {31'b0, $signed(a) < $signed(b)};
      decode_pkg::SLTU: alu_out = {31'b0, a < b};
      decode_pkg::XOR:  alu_out = a ^ b;
      decode_pkg::SRL:  alu_out = a >> b[4:0];
      decode_pkg::SRA:  alu_out = $signed(a) >>> b[4:0];
      decode_pkg::OR:   alu_out = a | b;
      decode_pkg::AND:  alu_out = a & b;
      default:          alu_out = a + b;
    endcase
  end

  assign legal = in.valid && !in.exc.illegal;

  // Write port of the register file, x0 writes dropped here
  assign we    = legal && in.wb.w_src != decode_pkg::NONE && in.wb.rd != '0;
  assign waddr = in.wb.rd;
  assign wdata = (in.wb.w_src == decode_pkg::PC4) ? in.wb.pc4 : alu_out;

  assign target    = in.jump.j_base + in.jump.j_offset;
  assign jump_now  = legal && in.jump.jump;
  assign fence_now = legal && in.exc.fence;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_valid    <= 1'b0;
      wb_rd       <= '0;
      wb_data     <= '0;
      jump_valid  <= 1'b0;
      jump_target <= '0;
      illegal     <= 1'b0;
      fence_pulse <= 1'b0;
      fence_prev  <= 1'b0;
    end else begin
      wb_valid    <= we;
      wb_rd       <= we ? waddr : '0;
      wb_data     <= we ? wdata : '0;
      jump_valid  <= jump_now;
      jump_target <= jump_now ? {target[31:1], target[0] & !in.jump.jalr} : '0;
      illegal     <= in.valid && in.exc.illegal;
      // Only the first fence of a run flushes, a bubble re-arms
      fence_pulse <= fence_now && !fence_prev;
      fence_prev  <= fence_now;
    end
  end

endmodule

// File: design/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          stall,
  input  logic          flush,
  decode_exec_if.buffer_in in,
  decode_exec_if.decode    out
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out.valid <= 1'b0;
      out.arith <= '0;
      out.wb    <= '0;
      out.jump  <= '0;
      out.exc   <= '0;
    end else if (stall || flush) begin
      // Bubble, the presented instruction is not taken
      out.valid <= 1'b0;
      out.arith <= '0;
      out.wb    <= '0;
      out.jump  <= '0;
      out.exc   <= '0;
    end else begin
      out.valid <= in.valid;
      out.arith <= in.arith;
      out.wb    <= in.wb;
      out.jump  <= in.jump;
      out.exc   <= in.exc;
    end
  end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                 CLK,
  input  logic                 nRST,
  input  decode_pkg::reg_idx_t raddr1,
  input  decode_pkg::reg_idx_t raddr2,
  output decode_pkg::word_t    rdata1,
  output decode_pkg::word_t    rdata2,
  input  logic                 we,
  input  decode_pkg::reg_idx_t waddr,
  input  decode_pkg::word_t    wdata
);

  // x0 has no storage
  decode_pkg::word_t regs [1:31];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Same-cycle write is forwarded to the readers
  assign rdata1 = (raddr1 == '0) ? '0 :
                  (we && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 :
                  (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

// File: project.f
design/decode_pkg.sv
design/decode_exec_if.sv
design/control_unit.sv
design/reg_file.sv
design/decode_stage.sv
design/id_ex_reg.sv
design/execute_unit.sv
design/decode_top.sv
bench/decode_assert.sv
bench/tb_decode.sv
